//--- dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_props.sv
dv/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FLIST     ?= dcache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/dcache_tb.sv
// data cache testbench
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tb;

  localparam int NUM_REQS  = 2000;
  localparam int MAX_WAIT  = 400;     // cycles allowed per response
  localparam int MAX_CYCLE = 200000;

  logic                    clk;
  logic                    rst_n;
  logic                    cpu_req;
  logic                    cpu_we;
  logic [31:0]             cpu_addr;
  logic [31:0]             cpu_wdata;
  logic [3:0]              cpu_wstrb;
  logic                    cpu_addr_ok;
  logic                    cpu_data_ok;
  logic [31:0]             cpu_rdata;
  logic                    mem_rd_req;
  logic [31:0]             mem_rd_addr;
  logic                    mem_rd_rdy;
  logic                    mem_ret_valid;
  dcache_pkg::cache_line_u mem_ret_data;
  logic                    mem_wr_req;
  logic [31:0]             mem_wr_addr;
  dcache_pkg::cache_line_u mem_wr_data;
  logic                    mem_wr_rdy;
  logic                    mem_wr_valid;

  logic [31:0] seed;
  logic [31:0] mem     [int unsigned];  // backing memory, word addressed
  logic [31:0] exp_mem [int unsigned];  // reference model
  bit          pend_we   [$];
  logic [31:0] pend_addr [$];
  logic [31:0] pend_val  [$];
  int          mismatches;
  int          failures;
  int          issued;
  int          wait_cnt;
  int          cycles;
  bit          acc_now;
  bit          hit_due;
  bit          last_valid;
  logic [31:0] last_addr;
  bit          rd_hold;
  bit          wr_hold;
  logic [31:0] rd_hold_addr;
  logic [31:0] wr_hold_addr;
  bit          rd_pend;
  bit          wr_pend;
  int          rd_cnt;
  int          wr_cnt;
  logic [31:0] rd_addr;

  dcache_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {16'h0, seed[30:15]};
  endfunction

  // two draws make one full word
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[15:0], lo[15:0]};
  endfunction

  // initial contents, depends on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[7:0], a[31:8]};
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem.exists(32'(a[31:2]))) return mem[32'(a[31:2])];
    return fill_word({a[31:2], 2'b00});
  endfunction

  function automatic logic [31:0] exp_word(input logic [31:0] a);
    if (exp_mem.exists(32'(a[31:2]))) return exp_mem[32'(a[31:2])];
    return fill_word({a[31:2], 2'b00});
  endfunction

  task automatic merge_store(input logic [31:0] a, input logic [3:0] strb,
                             input logic [31:0] d);
    logic [31:0] w;
    w = exp_word(a);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    exp_mem[32'(a[31:2])] = w;
  endtask

  // 4 tags x 4 sets x 4 words, forces conflict evictions
  function logic [31:0] random_addr();
    logic [19:0] tag;
    logic [7:0]  set;
    tag = 20'h12340 + 20'(next_rand() % 4);
    set = 8'(next_rand() % 4) * 8'd65 + 8'd3;
    return {tag, set, 2'(next_rand() % 4), 2'b00};
  endfunction

  // sampled at the falling edge, where everything is settled
  task automatic check_cycle();
    if (hit_due) begin
      assert (cpu_data_ok) else begin
        $display("no cpu_data_ok one cycle after a repeated load was accepted");
        failures++;
      end
      hit_due = 1'b0;
    end
    if (cpu_data_ok) begin
      wait_cnt = 0;
      assert (pend_we.size() > 0) else begin
        $display("cpu_data_ok with no request outstanding");
        failures++;
      end
      if (pend_we.size() > 0) begin
        if (!pend_we[0]) begin
          assert (cpu_rdata == pend_val[0]) else begin
            $display("MISMATCH cpu_rdata addr %h got %h exp %h",
                     pend_addr[0], cpu_rdata, pend_val[0]);
            mismatches++;
          end
          last_addr  = pend_addr[0];
          last_valid = 1'b1;
        end else begin
          last_valid = 1'b0;
        end
        void'(pend_we.pop_front());
        void'(pend_addr.pop_front());
        void'(pend_val.pop_front());
      end
    end else if (pend_we.size() > 0) begin
      wait_cnt++;
    end
    acc_now = cpu_req && cpu_addr_ok;
    if (acc_now) begin
      if (cpu_we) merge_store(cpu_addr, cpu_wstrb, cpu_wdata);
      pend_we.push_back(cpu_we);
      pend_addr.push_back(cpu_addr);
      pend_val.push_back(exp_word(cpu_addr));
      hit_due = !cpu_we && last_valid && (cpu_addr == last_addr);
    end
    // memory requests hold while not ready
    if (rd_hold) begin
      assert (mem_rd_req) else begin
        $display("mem_rd_req dropped while mem_rd_rdy was low");
        failures++;
      end
      assert (mem_rd_addr == rd_hold_addr) else begin
        $display("MISMATCH mem_rd_addr got %h exp %h", mem_rd_addr, rd_hold_addr);
        mismatches++;
      end
    end
    if (wr_hold) begin
      assert (mem_wr_req) else begin
        $display("mem_wr_req dropped while mem_wr_rdy was low");
        failures++;
      end
      assert (mem_wr_addr == wr_hold_addr) else begin
        $display("MISMATCH mem_wr_addr got %h exp %h", mem_wr_addr, wr_hold_addr);
        mismatches++;
      end
    end
    rd_hold      = mem_rd_req && !mem_rd_rdy;
    wr_hold      = mem_wr_req && !mem_wr_rdy;
    rd_hold_addr = mem_rd_addr;
    wr_hold_addr = mem_wr_addr;
    if (mem_rd_req && mem_rd_rdy) begin
      assert (mem_rd_addr[3:0] == 4'h0) else begin
        $display("MISMATCH mem_rd_addr got %h exp %h", mem_rd_addr,
                 {mem_rd_addr[31:4], 4'h0});
        mismatches++;
      end
      rd_addr = {mem_rd_addr[31:4], 4'h0};
      rd_pend = 1'b1;
      rd_cnt  = 1 + int'(next_rand() % 4);
    end
    if (mem_wr_req && mem_wr_rdy) begin
      assert (mem_wr_addr[3:0] == 4'h0) else begin
        $display("MISMATCH mem_wr_addr got %h exp %h", mem_wr_addr,
                 {mem_wr_addr[31:4], 4'h0});
        mismatches++;
      end
      for (int w = 0; w < `DCACHE_WORDS; w++) begin
        assert (mem_wr_data.words[w] == exp_word({mem_wr_addr[31:4], 2'(w), 2'b00}))
        else begin
          $display("MISMATCH mem_wr_data word %0d got %h exp %h", w,
                   mem_wr_data.words[w], exp_word({mem_wr_addr[31:4], 2'(w), 2'b00}));
          mismatches++;
        end
        mem[32'({mem_wr_addr[31:4], 2'(w)})] = mem_wr_data.words[w];
      end
      wr_pend = 1'b1;
      wr_cnt  = 1 + int'(next_rand() % 4);
    end
  endtask

  // driven at the rising edge
  task automatic drive_cycle();
    mem_ret_valid <= 1'b0;
    mem_wr_valid  <= 1'b0;
    if (rd_pend) begin
      if (rd_cnt == 0) begin
        mem_ret_valid <= 1'b1;
        for (int w = 0; w < `DCACHE_WORDS; w++) begin
          mem_ret_data.words[w] <= mem_word(rd_addr + 32'(4 * w));
        end
        rd_pend = 1'b0;
      end else begin
        rd_cnt--;
      end
    end
    if (wr_pend) begin
      if (wr_cnt == 0) begin
        mem_wr_valid <= 1'b1;
        wr_pend = 1'b0;
      end else begin
        wr_cnt--;
      end
    end
    mem_rd_rdy <= (next_rand() % 3) != 0;
    mem_wr_rdy <= (next_rand() % 3) != 0;
    if (acc_now || !cpu_req) begin
      if (issued < NUM_REQS && (next_rand() % 4) != 0) begin
        cpu_req   <= 1'b1;
        cpu_we    <= 1'(next_rand() % 2);
        cpu_addr  <= random_addr();
        cpu_wstrb <= 4'(next_rand());
        cpu_wdata <= rand_word();
        issued++;
      end else begin
        cpu_req <= 1'b0;
      end
    end
  endtask

  task automatic check_final_memory();
    logic [31:0] a;
    bit          held;
    foreach (exp_mem[k]) begin
      a    = {k[29:0], 2'b00};
      held = (u_dut.u_way0.valid_bits[a[11:4]] && u_dut.u_way0.dirty_bits[a[11:4]] &&
              u_dut.u_way0.tag_mem[a[11:4]] == a[31:12]) ||
             (u_dut.u_way1.valid_bits[a[11:4]] && u_dut.u_way1.dirty_bits[a[11:4]] &&
              u_dut.u_way1.tag_mem[a[11:4]] == a[31:12]);
      if (!held) begin
        assert (mem_word(a) == exp_mem[k]) else begin
          $display("MISMATCH memory word %h got %h exp %h", a, mem_word(a), exp_mem[k]);
          mismatches++;
        end
      end
    end
  endtask

  initial begin
    seed          = 32'd24165;
    rst_n         = 1'b0;
    cpu_req       = 1'b0;
    cpu_we        = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    cpu_wstrb     = '0;
    mem_rd_rdy    = 1'b0;
    mem_ret_valid = 1'b0;
    mem_ret_data  = '0;
    mem_wr_rdy    = 1'b0;
    mem_wr_valid  = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (cpu_addr_ok && !cpu_data_ok && !mem_rd_req && !mem_wr_req) else begin
      $display("handshake outputs wrong after reset");
      failures++;
    end
    while (!(issued == NUM_REQS && pend_we.size() == 0 && !cpu_req)) begin
      @(posedge clk);
      drive_cycle();
      @(negedge clk);
      check_cycle();
      cycles++;
      if (wait_cnt > MAX_WAIT || cycles > MAX_CYCLE) begin
        $display("timeout waiting for cpu_data_ok, %0d requests issued", issued);
        failures++;
        break;
      end
    end
    repeat (3) @(posedge clk);  // let a final store reach the array
    check_final_memory();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- dv/dcache_props.sv
// data cache bus properties
`timescale 1ns/1ps

module dcache_props (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      cpu_req,
  input logic                      cpu_addr_ok,
  input logic                      cpu_data_ok,
  input logic                      mem_rd_req,
  input logic                      mem_rd_rdy,
  input logic [31:0]               mem_rd_addr,
  input logic                      mem_wr_req,
  input logic                      mem_wr_rdy,
  input logic [31:0]               mem_wr_addr
);

  int outstanding;  // accepted requests without a response yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(cpu_req && cpu_addr_ok) - int'(cpu_data_ok);
    end
  end

  rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
    else $error("read request dropped or moved while not ready");

  wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_wr_req && !mem_wr_rdy |=> mem_wr_req && $stable(mem_wr_addr))
    else $error("write request dropped or moved while not ready");

  one_req: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rd_req && mem_wr_req))
    else $error("read and write requests together");

  resp_req: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_data_ok |-> outstanding != 0)
    else $error("response with no accepted request");

endmodule

bind dcache_top dcache_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .cpu_req     (cpu_req),
  .cpu_addr_ok (cpu_addr_ok),
  .cpu_data_ok (cpu_data_ok),
  .mem_rd_req  (mem_rd_req),
  .mem_rd_rdy  (mem_rd_rdy),
  .mem_rd_addr (mem_rd_addr),
  .mem_wr_req  (mem_wr_req),
  .mem_wr_rdy  (mem_wr_rdy),
  .mem_wr_addr (mem_wr_addr)
);

//--- verilog/dcache_top.sv
// two-way write-back data cache
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cpu_req,
  input  logic                     cpu_we,
  input  logic [31:0]              cpu_addr,
  input  logic [31:0]              cpu_wdata,
  input  logic [3:0]               cpu_wstrb,
  output logic                     cpu_addr_ok,
  output logic                     cpu_data_ok,
  output logic [31:0]              cpu_rdata,
  output logic                     mem_rd_req,
  output logic [31:0]              mem_rd_addr,
  input  logic                     mem_rd_rdy,
  input  logic                     mem_ret_valid,
  input  dcache_pkg::cache_line_u  mem_ret_data,
  output logic                     mem_wr_req,
  output logic [31:0]              mem_wr_addr,
  output dcache_pkg::cache_line_u  mem_wr_data,
  input  logic                     mem_wr_rdy,
  input  logic                     mem_wr_valid
);

  // shared by both ways
  logic [`DCACHE_INDEX_W-1:0] index;
  logic [`DCACHE_TAG_W-1:0]   lookup_tag;
  logic [`DCACHE_TAG_W-1:0]   refill_tag;
  logic [1:0]                 word_sel;
  logic [31:0]                word_wdata;

  logic [3:0]                 way0_wstrb;
  logic [3:0]                 way1_wstrb;
  logic                       way0_line_we;
  logic                       way1_line_we;
  logic                       way0_hit;
  logic                       way1_hit;
  logic                       way0_dirty;
  logic                       way1_dirty;
  logic [`DCACHE_TAG_W-1:0]   way0_tag;
  logic [`DCACHE_TAG_W-1:0]   way1_tag;
  dcache_pkg::cache_line_u    way0_line;
  dcache_pkg::cache_line_u    way1_line;

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_req       (cpu_req),
    .cpu_we        (cpu_we),
    .cpu_addr      (cpu_addr),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_wdata     (cpu_wdata),
    .cpu_addr_ok   (cpu_addr_ok),
    .cpu_data_ok   (cpu_data_ok),
    .cpu_rdata     (cpu_rdata),
    .mem_rd_req    (mem_rd_req),
    .mem_rd_addr   (mem_rd_addr),
    .mem_rd_rdy    (mem_rd_rdy),
    .mem_ret_valid (mem_ret_valid),
    .mem_wr_req    (mem_wr_req),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data),
    .mem_wr_rdy    (mem_wr_rdy),
    .mem_wr_valid  (mem_wr_valid),
    .way0_hit      (way0_hit),
    .way1_hit      (way1_hit),
    .way0_dirty    (way0_dirty),
    .way1_dirty    (way1_dirty),
    .way0_tag      (way0_tag),
    .way1_tag      (way1_tag),
    .way0_line     (way0_line),
    .way1_line     (way1_line),
    .index         (index),
    .lookup_tag    (lookup_tag),
    .word_sel      (word_sel),
    .word_wdata    (word_wdata),
    .way0_wstrb    (way0_wstrb),
    .way1_wstrb    (way1_wstrb),
    .way0_line_we  (way0_line_we),
    .way1_line_we  (way1_line_we),
    .refill_tag    (refill_tag)
  );

  dcache_way u_way0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .index       (index),
    .lookup_tag  (lookup_tag),
    .word_sel    (word_sel),
    .word_wstrb  (way0_wstrb),
    .word_wdata  (word_wdata),
    .line_we     (way0_line_we),
    .refill_tag  (refill_tag),
    .refill_line (mem_ret_data),  // refill straight from memory
    .hit         (way0_hit),
    .victim_tag  (way0_tag),
    .line        (way0_line),
    .dirty       (way0_dirty)
  );

  dcache_way u_way1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .index       (index),
    .lookup_tag  (lookup_tag),
    .word_sel    (word_sel),
    .word_wstrb  (way1_wstrb),
    .word_wdata  (word_wdata),
    .line_we     (way1_line_we),
    .refill_tag  (refill_tag),
    .refill_line (mem_ret_data),
    .hit         (way1_hit),
    .victim_tag  (way1_tag),
    .line        (way1_line),
    .dirty       (way1_dirty)
  );

endmodule

//--- verilog/dcache_ctrl.sv
// data cache controller
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cpu_req,
  input  logic                          cpu_we,
  input  logic [31:0]                   cpu_addr,
  input  logic [3:0]                    cpu_wstrb,
  input  logic [31:0]                   cpu_wdata,
  output logic                          cpu_addr_ok,
  output logic                          cpu_data_ok,
  output logic [31:0]                   cpu_rdata,
  output logic                          mem_rd_req,
  output logic [31:0]                   mem_rd_addr,
  input  logic                          mem_rd_rdy,
  input  logic                          mem_ret_valid,
  output logic                          mem_wr_req,
  output logic [31:0]                   mem_wr_addr,
  output dcache_pkg::cache_line_u       mem_wr_data,
  input  logic                          mem_wr_rdy,
  input  logic                          mem_wr_valid,
  input  logic                          way0_hit,
  input  logic                          way1_hit,
  input  logic                          way0_dirty,
  input  logic                          way1_dirty,
  input  logic [`DCACHE_TAG_W-1:0]      way0_tag,
  input  logic [`DCACHE_TAG_W-1:0]      way1_tag,
  input  dcache_pkg::cache_line_u       way0_line,
  input  dcache_pkg::cache_line_u       way1_line,
  output logic [`DCACHE_INDEX_W-1:0]    index,
  output logic [`DCACHE_TAG_W-1:0]      lookup_tag,
  output logic [1:0]                    word_sel,
  output logic [31:0]                   word_wdata,
  output logic [3:0]                    way0_wstrb,
  output logic [3:0]                    way1_wstrb,
  output logic                          way0_line_we,
  output logic                          way1_line_we,
  output logic [`DCACHE_TAG_W-1:0]      refill_tag
);

  dcache_pkg::dcache_state_e state;
  dcache_pkg::dcache_state_e state_nxt;

  logic                        accept;
  logic                        lookup_hit;
  logic                        refill_done;
  logic                        victim_way;     // 1 selects way1
  logic                        victim_dirty;
  logic [`DCACHE_TAG_W-1:0]    victim_tag;
  dcache_pkg::cache_line_u     hit_line;
  logic [`DCACHE_SETS-1:0]     repl;           // per set, the way not used last
  logic                        store_way;

  // request buffer
  logic                        buf_we;
  logic [`DCACHE_TAG_W-1:0]    buf_tag;
  logic [`DCACHE_INDEX_W-1:0]  buf_index;
  logic [1:0]                  buf_word;
  logic [3:0]                  buf_wstrb;
  logic [31:0]                 buf_wdata;

  assign accept      = cpu_req & cpu_addr_ok;
  assign lookup_hit  = (state == dcache_pkg::LOOKUP) & (way0_hit | way1_hit);
  assign refill_done = (state == dcache_pkg::REFILL) & mem_ret_valid;

  // a load hit frees the port in its own response cycle
  assign cpu_addr_ok = (state == dcache_pkg::IDLE) | (lookup_hit & ~buf_we);
  assign cpu_data_ok = lookup_hit;
  assign hit_line    = way1_hit ? way1_line : way0_line;
  assign cpu_rdata   = hit_line.words[buf_word];

  assign victim_way   = repl[buf_index];
  assign victim_dirty = victim_way ? way1_dirty : way0_dirty;
  assign victim_tag   = victim_way ? way1_tag : way0_tag;

  // array side
  assign index      = accept ? cpu_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W] : buf_index;
  assign lookup_tag = buf_tag;
  assign refill_tag = buf_tag;
  assign word_sel   = buf_word;
  assign word_wdata = buf_wdata;
  assign way0_wstrb = (state == dcache_pkg::STORE && !store_way) ? buf_wstrb : 4'b0000;
  assign way1_wstrb = (state == dcache_pkg::STORE && store_way) ? buf_wstrb : 4'b0000;
  assign way0_line_we = refill_done & ~victim_way;
  assign way1_line_we = refill_done & victim_way;

  // memory side, line aligned
  assign mem_rd_req  = (state == dcache_pkg::MISS_CLEAN);
  assign mem_rd_addr = {buf_tag, buf_index, {`DCACHE_OFFSET_W{1'b0}}};
  assign mem_wr_req  = (state == dcache_pkg::MISS_DIRTY);
  assign mem_wr_addr = {victim_tag, buf_index, {`DCACHE_OFFSET_W{1'b0}}};
  assign mem_wr_data = victim_way ? way1_line : way0_line;

  always_comb begin
    state_nxt = state;
    case (state)
      dcache_pkg::IDLE: begin
        if (accept) begin
          state_nxt = dcache_pkg::LOOKUP;
        end
      end
      dcache_pkg::LOOKUP: begin
        if (lookup_hit) begin
          if (buf_we) begin
            state_nxt = dcache_pkg::STORE;
          end else if (!accept) begin
            state_nxt = dcache_pkg::IDLE;
          end
        end else if (victim_dirty) begin
          state_nxt = dcache_pkg::MISS_DIRTY;
        end else begin
          state_nxt = dcache_pkg::MISS_CLEAN;
        end
      end
      dcache_pkg::STORE:      state_nxt = dcache_pkg::IDLE;
      dcache_pkg::MISS_DIRTY: begin
        if (mem_wr_rdy) begin
          state_nxt = dcache_pkg::WRITEBACK;
        end
      end
      dcache_pkg::WRITEBACK: begin
        if (mem_wr_valid) begin
          state_nxt = dcache_pkg::MISS_CLEAN;
        end
      end
      dcache_pkg::MISS_CLEAN: begin
        if (mem_rd_rdy) begin
          state_nxt = dcache_pkg::REFILL;
        end
      end
      dcache_pkg::REFILL: begin
        if (mem_ret_valid) begin
          state_nxt = dcache_pkg::RETRY;
        end
      end
      dcache_pkg::RETRY:      state_nxt = dcache_pkg::LOOKUP;
      default:                state_nxt = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcache_pkg::IDLE;
      repl  <= '0;
    end else begin
      state <= state_nxt;
      if (lookup_hit) begin
        repl[buf_index] <= way0_hit;  // other way becomes the victim
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      buf_we    <= cpu_we;
      buf_tag   <= cpu_addr[31 -: `DCACHE_TAG_W];
      buf_index <= cpu_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
      buf_word  <= cpu_addr[`DCACHE_OFFSET_W-1:2];
      buf_wstrb <= cpu_wstrb;
      buf_wdata <= cpu_wdata;
    end
    if (lookup_hit) begin
      store_way <= way1_hit;  // used by the STORE cycle
    end
  end

endmodule

//--- verilog/dcache_way.sv
// data cache way storage
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_way (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`DCACHE_INDEX_W-1:0]    index,
  input  logic [`DCACHE_TAG_W-1:0]      lookup_tag,
  input  logic [1:0]                    word_sel,
  input  logic [3:0]                    word_wstrb,
  input  logic [31:0]                   word_wdata,
  input  logic                          line_we,
  input  logic [`DCACHE_TAG_W-1:0]      refill_tag,
  input  dcache_pkg::cache_line_u       refill_line,
  output logic                          hit,
  output logic [`DCACHE_TAG_W-1:0]      victim_tag,
  output dcache_pkg::cache_line_u       line,
  output logic                          dirty
);

  logic [`DCACHE_TAG_W-1:0] tag_mem [`DCACHE_SETS];
  dcache_pkg::cache_line_u  data_mem [`DCACHE_SETS];
  logic [`DCACHE_SETS-1:0]  valid_bits;
  logic [`DCACHE_SETS-1:0]  dirty_bits;
  logic                     valid_q;    // valid of the set read last cycle
  logic                     word_we;

  assign word_we = |word_wstrb;

  // tag and data arrays, read one cycle after index
  always_ff @(posedge clk) begin
    if (line_we) begin
      tag_mem[index]  <= refill_tag;
      data_mem[index] <= refill_line;
    end else if (word_we) begin
      for (int b = 0; b < 4; b++) begin
        if (word_wstrb[b]) begin
          data_mem[index].words[word_sel][8*b +: 8] <= word_wdata[8*b +: 8];
        end
      end
    end
    victim_tag <= tag_mem[index];   // old contents on a same-cycle write
    line       <= data_mem[index];
  end

  // state bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      valid_q    <= 1'b0;
      dirty      <= 1'b0;
    end else begin
      if (line_we) begin
        valid_bits[index] <= 1'b1;
        dirty_bits[index] <= 1'b0;  // fresh from memory
      end else if (word_we) begin
        dirty_bits[index] <= 1'b1;
      end
      valid_q <= valid_bits[index];
      dirty   <= dirty_bits[index];
    end
  end

  // stored tag doubles as the compare tag
  assign hit = valid_q & (victim_tag == lookup_tag);

endmodule

//--- verilog/dcache_pkg.sv
// data cache types
`include "dcache_macros.svh"

package dcache_pkg;

  // one line, as a bus word or as four words (word 0 low)
  typedef union packed {
    logic [`DCACHE_LINE_W-1:0]            flat;
    logic [`DCACHE_WORDS-1:0][31:0]       words;
  } cache_line_u;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,
    MISS_DIRTY,   // victim must go out first
    WRITEBACK,
    MISS_CLEAN,
    REFILL,
    RETRY         // re-read the refilled set
  } dcache_state_e;

endpackage

//--- verilog/dcache_macros.svh
// data cache geometry
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// two ways, 256 sets of 16-byte lines
`define DCACHE_SETS      256
`define DCACHE_INDEX_W   8

// address bits 31:12
`define DCACHE_TAG_W     20

`define DCACHE_OFFSET_W  4    // byte within a line

`define DCACHE_WORDS     4
`define DCACHE_LINE_W    128  // whole line as one bus word

`endif
